//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_offload_reduction
RTL_TOP   ?= offload_reduction
FLIST     ?= src.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing --assert

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FLIST) --top-module $(TOP)

$(BUILD_DIR)/V$(TOP): $(shell cat $(FLIST) | grep -v '^+') hdl/red_cfg.svh
	$(VERILATOR) --binary $(VFLAGS) -f $(FLIST) --top-module $(TOP) -Mdir $(BUILD_DIR)

sim: $(BUILD_DIR)/V$(TOP)
	-./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "TEST FAILED" $(LOG); then \
		echo "Simulation reported a failure, see $(LOG)"; exit 1; \
	fi
	@if ! grep -q "TEST OK" $(LOG); then \
		echo "Simulation ended without a result, see $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- hdl/offload_reduction.sv
`timescale 1ns/1ps
`include "red_cfg.svh"

// Offload reduction datapath of a four-route router
// Operands go to an external reduction unit and results come back in order
module offload_reduction (
  input  logic                      clk_i,
  input  logic                      rst_n_i,
  input  red_types_pkg::route_mask_t valid_i,
  output red_types_pkg::route_mask_t ready_o,
  input  red_types_pkg::red_hdr_t    hdr_i [`RED_NUM_ROUTES],
  input  red_types_pkg::red_data_t   data_i [`RED_NUM_ROUTES],
  input  red_types_pkg::route_mask_t exp_mask_i [`RED_NUM_ROUTES],
  input  red_types_pkg::route_mask_t out_mask_i [`RED_NUM_ROUTES],
  output red_types_pkg::route_mask_t valid_o,
  input  red_types_pkg::route_mask_t ready_i,
  output red_types_pkg::red_hdr_t    hdr_o [`RED_NUM_ROUTES],
  output red_types_pkg::red_data_t   data_o [`RED_NUM_ROUTES],
  output logic                      req_valid_o,
  input  logic                      req_ready_i,
  output red_ctrl_pkg::red_op_e      req_op_o,
  output red_types_pkg::red_data_t   req_op1_o,
  output red_types_pkg::red_data_t   req_op2_o,
  input  logic                      resp_valid_i,
  output logic                      resp_ready_o,
  input  red_types_pkg::red_data_t   resp_data_i
);

  // FIFO heads
  red_types_pkg::route_mask_t head_valid;
  red_types_pkg::red_hdr_t    head_hdr [`RED_NUM_ROUTES];
  red_types_pkg::red_data_t   head_data [`RED_NUM_ROUTES];
  red_types_pkg::route_mask_t head_exp [`RED_NUM_ROUTES];
  red_types_pkg::route_mask_t head_out [`RED_NUM_ROUTES];

  // Controller outputs
  red_types_pkg::route_mask_t pop;
  red_types_pkg::route_idx_t  sel_a;
  red_types_pkg::route_idx_t  sel_b;
  logic                       use_part;
  logic                       req_final;

  // Queue and response steering
  red_types_pkg::inflight_cnt_t q_cnt;
  logic                         q_head_final;
  red_types_pkg::red_hdr_t      q_head_hdr;
  red_types_pkg::route_mask_t   q_head_out_mask;
  red_types_pkg::red_hdr_t      chain_hdr_q;
  red_types_pkg::red_hdr_t      push_hdr;
  logic                         req_fire;
  logic                         resp_fire;
  logic                         resp_pending;
  logic                         part_we;
  logic                         part_written;
  logic                         fork_valid;
  logic                         fork_ready;

  for (genvar i = 0; i < `RED_NUM_ROUTES; i++) begin : gen_route
    red_in_fifo i_in_fifo (
      .clk_i           (clk_i),
      .rst_n_i         (rst_n_i),
      .push_valid_i    (valid_i[i]),
      .push_ready_o    (ready_o[i]),
      .hdr_i           (hdr_i[i]),
      .data_i          (data_i[i]),
      .exp_mask_i      (exp_mask_i[i]),
      .out_mask_i      (out_mask_i[i]),
      .pop_i           (pop[i]),
      .head_valid_o    (head_valid[i]),
      .head_hdr_o      (head_hdr[i]),
      .head_data_o     (head_data[i]),
      .head_exp_mask_o (head_exp[i]),
      .head_out_mask_o (head_out[i])
    );

    // Every output route sees the same final flit
    assign hdr_o[i]  = q_head_hdr;
    assign data_o[i] = resp_data_i;
  end

  red_ctrl_fsm i_ctrl_fsm (
    .clk_i           (clk_i),
    .rst_n_i         (rst_n_i),
    .head_valid_i    (head_valid),
    .head_exp_mask_i (head_exp),
    .head_hdr_i      (head_hdr),
    .req_ready_i     (req_ready_i),
    .inflight_cnt_i  (q_cnt),
    .part_written_i  (part_written),
    .pop_o           (pop),
    .sel_a_o         (sel_a),
    .sel_b_o         (sel_b),
    .use_part_o      (use_part),
    .req_valid_o     (req_valid_o),
    .req_op_o        (req_op_o),
    .req_final_o     (req_final)
  );

  assign req_fire  = req_valid_o & req_ready_i;
  assign resp_fire = resp_valid_i & resp_ready_o;

  // The lowest route leaves its FIFO with the first pair, so its header is kept for the chain
  always_ff @(posedge clk_i) begin
    if (req_fire && !use_part) begin
      chain_hdr_q <= head_hdr[sel_a];
    end
  end

  assign push_hdr = use_part ? chain_hdr_q : head_hdr[sel_a];

  red_inflight_queue i_inflight_queue (
    .clk_i           (clk_i),
    .rst_n_i         (rst_n_i),
    .push_i          (req_fire),
    .push_final_i    (req_final),
    .push_hdr_i      (push_hdr),
    .push_out_mask_i (head_out[sel_b]),
    .pop_i           (resp_fire),
    .cnt_o           (q_cnt),
    .head_final_o    (q_head_final),
    .head_hdr_o      (q_head_hdr),
    .head_out_mask_o (q_head_out_mask)
  );

  red_operand_path i_operand_path (
    .clk_i          (clk_i),
    .rst_n_i        (rst_n_i),
    .head_data_i    (head_data),
    .sel_a_i        (sel_a),
    .sel_b_i        (sel_b),
    .use_part_i     (use_part),
    .resp_data_i    (resp_data_i),
    .part_we_i      (part_we),
    .op1_o          (req_op1_o),
    .op2_o          (req_op2_o),
    .part_written_o (part_written)
  );

  // A response is only expected while the queue holds a record
  assign resp_pending = (q_cnt != '0);

  // Final results go to the fork, partial ones into the partial register
  // The partial register never blocks since the controller waits for it
  assign fork_valid   = resp_valid_i & resp_pending & q_head_final;
  assign part_we      = resp_valid_i & resp_pending & ~q_head_final;
  assign resp_ready_o = resp_pending & (~q_head_final | fork_ready);

  red_out_fork i_out_fork (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .in_valid_i  (fork_valid),
    .in_ready_o  (fork_ready),
    .sel_mask_i  (q_head_out_mask),
    .out_valid_o (valid_o),
    .out_ready_i (ready_i)
  );

endmodule

//--- hdl/red_cfg.svh
`ifndef RED_CFG_SVH
`define RED_CFG_SVH

// Number of router routes, used for both the input and the output side
`define RED_NUM_ROUTES 4

// Width of one operand and of one reduction result
`define RED_DATA_W 32

// Width of the flit header, its low two bits carry the operation
`define RED_HDR_W 8

// Entries per input FIFO
`define RED_FIFO_DEPTH 2

// Requests that may wait on the reduction unit at the same time
`define RED_MAX_INFLIGHT 4

// Bits needed to address one route
`define RED_ROUTE_IDX_W 2

`endif

//--- hdl/red_ctrl_fsm.sv
`timescale 1ns/1ps
`include "red_cfg.svh"

// Stalling reduction controller
// Two-input reductions go out as final requests back to back
// Wider reductions build one partial result and chain the remaining routes onto it
module red_ctrl_fsm (
  input  logic                       clk_i,
  input  logic                       rst_n_i,
  input  red_types_pkg::route_mask_t  head_valid_i,
  input  red_types_pkg::route_mask_t  head_exp_mask_i [`RED_NUM_ROUTES],
  input  red_types_pkg::red_hdr_t     head_hdr_i [`RED_NUM_ROUTES],
  input  logic                       req_ready_i,
  input  red_types_pkg::inflight_cnt_t inflight_cnt_i,
  input  logic                       part_written_i,
  output red_types_pkg::route_mask_t  pop_o,
  output red_types_pkg::route_idx_t   sel_a_o,
  output red_types_pkg::route_idx_t   sel_b_o,
  output logic                       use_part_o,
  output logic                       req_valid_o,
  output red_ctrl_pkg::red_op_e       req_op_o,
  output logic                       req_final_o
);

  red_ctrl_pkg::red_state_e   state_q;
  red_types_pkg::route_mask_t remain_q;
  red_ctrl_pkg::red_op_e      op_q;

  red_types_pkg::route_idx_t  ref_idx;
  red_types_pkg::route_mask_t ref_exp;
  red_types_pkg::route_idx_t  idx_a;
  red_types_pkg::route_idx_t  idx_b;
  red_types_pkg::route_idx_t  idx_c;
  red_types_pkg::route_mask_t bit_a;
  red_types_pkg::route_mask_t bit_b;
  red_types_pkg::route_mask_t bit_c;
  red_types_pkg::route_mask_t rest_b;
  logic                       cnt_ok;
  logic                       cnt_zero;
  logic                       fire;

  // Index of the lowest set bit, zero for an empty mask
  function automatic red_types_pkg::route_idx_t lowest_idx(
    input red_types_pkg::route_mask_t m
  );
    red_types_pkg::route_idx_t idx;
    idx = '0;
    for (int i = `RED_NUM_ROUTES - 1; i >= 0; i--) begin
      if (m[i]) begin
        idx = red_types_pkg::route_idx_t'(i);
      end
    end
    return idx;
  endfunction

  // Header bits 1:0 pick the operation, the unused code falls back to add
  function automatic red_ctrl_pkg::red_op_e decode_op(input red_types_pkg::red_hdr_t hdr);
    case (hdr[1:0])
      2'd1:    return red_ctrl_pkg::RED_MIN;
      2'd2:    return red_ctrl_pkg::RED_MAX;
      default: return red_ctrl_pkg::RED_ADD;
    endcase
  endfunction

  // The lowest valid head decides which reduction is next
  assign ref_idx = lowest_idx(head_valid_i);
  assign ref_exp = head_exp_mask_i[ref_idx];

  // First pair is the two lowest routes of the expected mask
  assign idx_a  = lowest_idx(ref_exp);
  assign bit_a  = red_types_pkg::route_mask_t'(1) << idx_a;
  assign idx_b  = lowest_idx(ref_exp & ~bit_a);
  assign bit_b  = red_types_pkg::route_mask_t'(1) << idx_b;
  assign rest_b = ref_exp & ~bit_a & ~bit_b;

  // During the chain the next route is the lowest one not yet reduced
  assign idx_c = lowest_idx(remain_q);
  assign bit_c = red_types_pkg::route_mask_t'(1) << idx_c;

  assign cnt_ok   = inflight_cnt_i < red_types_pkg::inflight_cnt_t'(`RED_MAX_INFLIGHT);
  assign cnt_zero = (inflight_cnt_i == '0);
  assign fire     = req_valid_o & req_ready_i;

  always_comb begin
    sel_a_o     = idx_a;
    sel_b_o     = idx_b;
    use_part_o  = 1'b0;
    req_valid_o = 1'b0;
    req_op_o    = decode_op(head_hdr_i[ref_idx]);
    req_final_o = (rest_b == '0);
    pop_o       = '0;
    case (state_q)
      red_ctrl_pkg::ST_IDLE: begin
        // A partial request must be alone in the pipe, a final one only needs room
        req_valid_o = (|head_valid_i) && ((ref_exp & head_valid_i) == ref_exp) &&
                      (req_final_o ? cnt_ok : cnt_zero);
        if (req_valid_o && req_ready_i) begin
          pop_o = bit_a | bit_b;
        end
      end
      red_ctrl_pkg::ST_CHAIN: begin
        use_part_o  = 1'b1;
        sel_b_o     = idx_c;
        req_op_o    = op_q;
        req_final_o = ((remain_q & ~bit_c) == '0);
        req_valid_o = head_valid_i[idx_c] && (req_final_o ? cnt_ok : cnt_zero);
        if (req_valid_o && req_ready_i) begin
          pop_o = bit_c;
        end
      end
      default: begin
        // Waiting for the partial result, nothing is issued
      end
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state_q  <= red_ctrl_pkg::ST_IDLE;
      remain_q <= '0;
      op_q     <= red_ctrl_pkg::RED_ADD;
    end else begin
      case (state_q)
        red_ctrl_pkg::ST_IDLE: begin
          if (fire && !req_final_o) begin
            state_q  <= red_ctrl_pkg::ST_WAIT_PART;
            remain_q <= rest_b;
            op_q     <= req_op_o;
          end
        end
        red_ctrl_pkg::ST_WAIT_PART: begin
          if (part_written_i) begin
            state_q <= red_ctrl_pkg::ST_CHAIN;
          end
        end
        red_ctrl_pkg::ST_CHAIN: begin
          if (fire) begin
            remain_q <= remain_q & ~bit_c;
            state_q  <= req_final_o ? red_ctrl_pkg::ST_IDLE : red_ctrl_pkg::ST_WAIT_PART;
          end
        end
        default: state_q <= red_ctrl_pkg::ST_IDLE;
      endcase
    end
  end

endmodule

//--- hdl/red_ctrl_pkg.sv
// Encodings of the reduction controller
package red_ctrl_pkg;

  // Operation sent to the reduction unit
  typedef enum logic [1:0] {
    RED_ADD = 2'd0,
    RED_MIN = 2'd1,
    RED_MAX = 2'd2
  } red_op_e;

  // Controller states of the stalling scheme
  typedef enum logic [1:0] {
    ST_IDLE      = 2'd0,
    ST_WAIT_PART = 2'd1,
    ST_CHAIN     = 2'd2
  } red_state_e;

endpackage

//--- hdl/red_in_fifo.sv
`timescale 1ns/1ps
`include "red_cfg.svh"

// Input buffer of one route
// The head is read from storage, so nothing passes from push to pop in one cycle
module red_in_fifo (
  input  logic                      clk_i,
  input  logic                      rst_n_i,
  input  logic                      push_valid_i,
  output logic                      push_ready_o,
  input  red_types_pkg::red_hdr_t    hdr_i,
  input  red_types_pkg::red_data_t   data_i,
  input  red_types_pkg::route_mask_t exp_mask_i,
  input  red_types_pkg::route_mask_t out_mask_i,
  input  logic                      pop_i,
  output logic                      head_valid_o,
  output red_types_pkg::red_hdr_t    head_hdr_o,
  output red_types_pkg::red_data_t   head_data_o,
  output red_types_pkg::route_mask_t head_exp_mask_o,
  output red_types_pkg::route_mask_t head_out_mask_o
);

  localparam int unsigned ptr_w = (`RED_FIFO_DEPTH > 1) ? $clog2(`RED_FIFO_DEPTH) : 1;
  localparam int unsigned cnt_w = $clog2(`RED_FIFO_DEPTH + 1);

  // Flit storage, one entry per slot
  red_types_pkg::red_hdr_t    hdr_mem  [`RED_FIFO_DEPTH];
  red_types_pkg::red_data_t   data_mem [`RED_FIFO_DEPTH];
  red_types_pkg::route_mask_t exp_mem  [`RED_FIFO_DEPTH];
  red_types_pkg::route_mask_t out_mem  [`RED_FIFO_DEPTH];

  logic [ptr_w-1:0] wr_ptr_q;
  logic [ptr_w-1:0] rd_ptr_q;
  logic [cnt_w-1:0] fill_q;
  logic             push;
  logic             pop;

  // Advance a pointer and wrap at the last slot
  function automatic logic [ptr_w-1:0] next_ptr(input logic [ptr_w-1:0] ptr);
    if (ptr == ptr_w'(`RED_FIFO_DEPTH - 1)) begin
      return '0;
    end
    return ptr + 1'b1;
  endfunction

  assign push_ready_o = (fill_q != cnt_w'(`RED_FIFO_DEPTH));
  assign head_valid_o = (fill_q != '0);

  // The controller only pops a valid head, the guard keeps the count safe anyway
  assign push = push_valid_i & push_ready_o;
  assign pop  = pop_i & head_valid_o;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      fill_q   <= '0;
    end else begin
      if (push) begin
        wr_ptr_q <= next_ptr(wr_ptr_q);
      end
      if (pop) begin
        rd_ptr_q <= next_ptr(rd_ptr_q);
      end
      fill_q <= fill_q + cnt_w'(push) - cnt_w'(pop);
    end
  end

  always_ff @(posedge clk_i) begin
    if (push) begin
      hdr_mem[wr_ptr_q]  <= hdr_i;
      data_mem[wr_ptr_q] <= data_i;
      exp_mem[wr_ptr_q]  <= exp_mask_i;
      out_mem[wr_ptr_q]  <= out_mask_i;
    end
  end

  assign head_hdr_o      = hdr_mem[rd_ptr_q];
  assign head_data_o     = data_mem[rd_ptr_q];
  assign head_exp_mask_o = exp_mem[rd_ptr_q];
  assign head_out_mask_o = out_mem[rd_ptr_q];

endmodule

//--- hdl/red_inflight_queue.sv
`timescale 1ns/1ps
`include "red_cfg.svh"

// Book-keeping for requests that sit in the reduction unit
// Responses come back in request order, so the oldest record describes the current response
module red_inflight_queue (
  input  logic                         clk_i,
  input  logic                         rst_n_i,
  input  logic                         push_i,
  input  logic                         push_final_i,
  input  red_types_pkg::red_hdr_t       push_hdr_i,
  input  red_types_pkg::route_mask_t    push_out_mask_i,
  input  logic                         pop_i,
  output red_types_pkg::inflight_cnt_t  cnt_o,
  output logic                         head_final_o,
  output red_types_pkg::red_hdr_t       head_hdr_o,
  output red_types_pkg::route_mask_t    head_out_mask_o
);

  localparam int unsigned ptr_w = (`RED_MAX_INFLIGHT > 1) ? $clog2(`RED_MAX_INFLIGHT) : 1;

  // One record per outstanding request
  logic                       final_mem [`RED_MAX_INFLIGHT];
  red_types_pkg::red_hdr_t    hdr_mem   [`RED_MAX_INFLIGHT];
  red_types_pkg::route_mask_t mask_mem  [`RED_MAX_INFLIGHT];

  logic [ptr_w-1:0]             wr_ptr_q;
  logic [ptr_w-1:0]             rd_ptr_q;
  red_types_pkg::inflight_cnt_t cnt_q;

  function automatic logic [ptr_w-1:0] next_ptr(input logic [ptr_w-1:0] ptr);
    if (ptr == ptr_w'(`RED_MAX_INFLIGHT - 1)) begin
      return '0;
    end
    return ptr + 1'b1;
  endfunction

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      cnt_q    <= '0;
    end else begin
      if (push_i) begin
        wr_ptr_q <= next_ptr(wr_ptr_q);
      end
      if (pop_i) begin
        rd_ptr_q <= next_ptr(rd_ptr_q);
      end
      // Push and pop in one cycle leave the count as it is
      cnt_q <= cnt_q + red_types_pkg::inflight_cnt_t'(push_i)
                     - red_types_pkg::inflight_cnt_t'(pop_i);
    end
  end

  always_ff @(posedge clk_i) begin
    if (push_i) begin
      final_mem[wr_ptr_q] <= push_final_i;
      hdr_mem[wr_ptr_q]   <= push_hdr_i;
      mask_mem[wr_ptr_q]  <= push_out_mask_i;
    end
  end

  assign cnt_o           = cnt_q;
  assign head_final_o    = final_mem[rd_ptr_q];
  assign head_hdr_o      = hdr_mem[rd_ptr_q];
  assign head_out_mask_o = mask_mem[rd_ptr_q];

endmodule

//--- hdl/red_operand_path.sv
`timescale 1ns/1ps
`include "red_cfg.svh"

// Operand selection towards the reduction unit and the single partial result entry
module red_operand_path (
  input  logic                      clk_i,
  input  logic                      rst_n_i,
  input  red_types_pkg::red_data_t   head_data_i [`RED_NUM_ROUTES],
  input  red_types_pkg::route_idx_t  sel_a_i,
  input  red_types_pkg::route_idx_t  sel_b_i,
  input  logic                      use_part_i,
  input  red_types_pkg::red_data_t   resp_data_i,
  input  logic                      part_we_i,
  output red_types_pkg::red_data_t   op1_o,
  output red_types_pkg::red_data_t   op2_o,
  output logic                      part_written_o
);

  red_types_pkg::red_data_t part_q;
  logic                     part_written_q;

  // Only one reduction can be in its chain, so one entry is enough
  always_ff @(posedge clk_i) begin
    if (part_we_i) begin
      part_q <= resp_data_i;
    end
  end

  // Tells the controller that the partial value can be read from now on
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      part_written_q <= 1'b0;
    end else begin
      part_written_q <= part_we_i;
    end
  end

  // In a chain the partial is always the first operand
  assign op1_o          = use_part_i ? part_q : head_data_i[sel_a_i];
  assign op2_o          = head_data_i[sel_b_i];
  assign part_written_o = part_written_q;

endmodule

//--- hdl/red_out_fork.sv
`timescale 1ns/1ps
`include "red_cfg.svh"

// Dynamic fork of one result to the routes of its output mask
// Each route takes the result on its own handshake
module red_out_fork (
  input  logic                      clk_i,
  input  logic                      rst_n_i,
  input  logic                      in_valid_i,
  output logic                      in_ready_o,
  input  red_types_pkg::route_mask_t sel_mask_i,
  output red_types_pkg::route_mask_t out_valid_o,
  input  red_types_pkg::route_mask_t out_ready_i
);

  // Routes that already took the current result
  red_types_pkg::route_mask_t sent_q;

  assign out_valid_o = {`RED_NUM_ROUTES{in_valid_i}} & sel_mask_i & ~sent_q;

  // Done once every selected route took it before or takes it now
  assign in_ready_o = &(sent_q | out_ready_i | ~sel_mask_i);

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      sent_q <= '0;
    end else if (in_valid_i && in_ready_o) begin
      sent_q <= '0;
    end else begin
      sent_q <= sent_q | (out_valid_o & out_ready_i);
    end
  end

endmodule

//--- hdl/red_types_pkg.sv
`include "red_cfg.svh"

// Vector types of the reduction datapath
package red_types_pkg;

  // Operand and result word
  typedef logic [`RED_DATA_W-1:0] red_data_t;

  // Flit header as seen on the routes
  typedef logic [`RED_HDR_W-1:0] red_hdr_t;

  // One bit per route, used for the expected-input and output masks
  typedef logic [`RED_NUM_ROUTES-1:0] route_mask_t;

  // Route number
  typedef logic [`RED_ROUTE_IDX_W-1:0] route_idx_t;

  // Outstanding request count, wide enough to hold the limit itself
  typedef logic [$clog2(`RED_MAX_INFLIGHT+1)-1:0] inflight_cnt_t;

endpackage

//--- src.f
+incdir+hdl
hdl/red_types_pkg.sv
hdl/red_ctrl_pkg.sv
hdl/red_in_fifo.sv
hdl/red_ctrl_fsm.sv
hdl/red_inflight_queue.sv
hdl/red_operand_path.sv
hdl/red_out_fork.sv
hdl/offload_reduction.sv
test/offload_reduction_chk.sv
test/tb_offload_reduction.sv

//--- test/offload_reduction_chk.sv
`timescale 1ns/1ps
`include "red_cfg.svh"

// Protocol checker bound to the reduction top level
module offload_reduction_chk (
  input logic                       clk_i,
  input logic                       rst_n_i,
  input red_types_pkg::route_mask_t valid_i,
  input red_types_pkg::route_mask_t ready_o,
  input red_types_pkg::route_mask_t valid_o,
  input red_types_pkg::route_mask_t ready_i,
  input red_types_pkg::red_data_t   data_o [`RED_NUM_ROUTES],
  input logic                       req_valid_o,
  input logic                       req_ready_i,
  input red_types_pkg::red_data_t   req_op1_o,
  input red_types_pkg::red_data_t   req_op2_o,
  input logic                       resp_valid_i,
  input logic                       resp_ready_o
);

  int fail_cnt = 0;
  // Requests sent to the reduction unit and not yet answered
  int outstanding;
  // Set by the first flit that enters any input FIFO after reset
  logic flit_seen;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      outstanding <= 0;
      flit_seen   <= 1'b0;
    end else begin
      outstanding <= outstanding + int'(req_valid_o && req_ready_i)
                                 - int'(resp_valid_i && resp_ready_o);
      if ((valid_i & ready_o) != '0) begin
        flit_seen <= 1'b1;
      end
    end
  end

  // Nothing leaves the DUT between reset and the first accepted flit
  reset_quiet: assert property (@(posedge clk_i) !flit_seen |->
      (!req_valid_o && !resp_ready_o && valid_o == '0))
    else begin fail_cnt++; $error("outputs active before any flit arrived"); end

  // A raised request keeps its operands until it transfers
  req_hold: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      req_valid_o && !req_ready_i |=> req_valid_o && $stable(req_op1_o) && $stable(req_op2_o))
    else begin fail_cnt++; $error("request dropped or changed before its transfer"); end

  inflight_limit: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      outstanding <= `RED_MAX_INFLIGHT)
    else begin
      fail_cnt++;
      $error("mismatch outstanding 0x%0h above limit 0x%0h", outstanding, `RED_MAX_INFLIGHT);
    end

  // Responses are only taken while a request is outstanding
  resp_owned: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      resp_ready_o |-> outstanding != 0)
    else begin fail_cnt++; $error("resp_ready_o high with no request outstanding"); end

  for (genvar r = 0; r < `RED_NUM_ROUTES; r++) begin : gen_out
    out_hold: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        valid_o[r] && !ready_i[r] |=> valid_o[r] && $stable(data_o[r]))
      else begin fail_cnt++; $error("valid_o of route %0d dropped before its transfer", r); end
  end

endmodule

bind offload_reduction offload_reduction_chk u_chk (
  .clk_i        (clk_i),
  .rst_n_i      (rst_n_i),
  .valid_i      (valid_i),
  .ready_o      (ready_o),
  .valid_o      (valid_o),
  .ready_i      (ready_i),
  .data_o       (data_o),
  .req_valid_o  (req_valid_o),
  .req_ready_i  (req_ready_i),
  .req_op1_o    (req_op1_o),
  .req_op2_o    (req_op2_o),
  .resp_valid_i (resp_valid_i),
  .resp_ready_o (resp_ready_o)
);

//--- test/tb_offload_reduction.sv
`timescale 1ns/1ps
`include "red_cfg.svh"

// Testbench of the offload reduction datapath
// Holds the reduction unit model, the flit stimulus and the scoreboard of expected results
module tb_offload_reduction;

  localparam int clk_period    = 10;
  localparam int num_tests     = 40;
  localparam int warmup_tests  = 10;
  localparam int model_latency = 3;
  localparam logic [15:0] lfsr_seed = 16'd30976;
  // Every reduction may take up to 200 ns, reset and drain come on top
  localparam int timeout_ns = num_tests * 200 + 20 * clk_period;

  logic                       clk_i;
  logic                       rst_n_i;
  red_types_pkg::route_mask_t valid_i;
  red_types_pkg::route_mask_t ready_o;
  red_types_pkg::red_hdr_t    hdr_i [`RED_NUM_ROUTES];
  red_types_pkg::red_data_t   data_i [`RED_NUM_ROUTES];
  red_types_pkg::route_mask_t exp_mask_i [`RED_NUM_ROUTES];
  red_types_pkg::route_mask_t out_mask_i [`RED_NUM_ROUTES];
  red_types_pkg::route_mask_t valid_o;
  red_types_pkg::route_mask_t ready_i;
  red_types_pkg::red_hdr_t    hdr_o [`RED_NUM_ROUTES];
  red_types_pkg::red_data_t   data_o [`RED_NUM_ROUTES];
  logic                       req_valid_o;
  logic                       req_ready_i;
  red_ctrl_pkg::red_op_e      req_op_o;
  red_types_pkg::red_data_t   req_op1_o;
  red_types_pkg::red_data_t   req_op2_o;
  logic                       resp_valid_i;
  logic                       resp_ready_o;
  red_types_pkg::red_data_t   resp_data_i;

  // Flits waiting per route, packed as header, data, expected mask and output mask
  logic [47:0]              stim_q [`RED_NUM_ROUTES][$];
  // Expected header and data per output route in arrival order
  logic [39:0]              expect_q [`RED_NUM_ROUTES][$];
  // Reduction unit pipeline, results with the cycle they become visible
  red_types_pkg::red_data_t model_q [$];
  int                       due_q [$];
  logic [15:0]              lfsr_q;
  logic                     started;
  logic                     overlap_seen;
  int                       cycle;
  int                       total_out;
  int                       recv_cnt;

  offload_reduction DUT (.*);

  initial begin
    clk_i = 1'b0;
    forever #(clk_period / 2) clk_i = ~clk_i;
  end

  // Fibonacci LFSR with taps 16, 14, 13 and 11, one step per returned bit
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    logic        fb;
    v = '0;
    for (int i = 0; i < n; i++) begin
      fb     = lfsr_q[15] ^ lfsr_q[13] ^ lfsr_q[12] ^ lfsr_q[10];
      lfsr_q = {lfsr_q[14:0], fb};
      v      = {v[30:0], fb};
    end
    return v;
  endfunction

  // Add wraps at 32 bits, min and max compare unsigned
  function automatic red_types_pkg::red_data_t reduce_pair(input logic [1:0] op,
      input red_types_pkg::red_data_t a, input red_types_pkg::red_data_t b);
    case (op)
      red_ctrl_pkg::RED_MIN: return (a < b) ? a : b;
      red_ctrl_pkg::RED_MAX: return (a > b) ? a : b;
      default:               return a + b;
    endcase
  endfunction

  task automatic stop_with_failure(input string why);
    $display("%s", why);
    $display("TEST FAILED");
    $fatal(1, "simulation stopped at the first error");
  endtask

  // Every reduction includes route 0, so reductions issue in the order they are built here
  task automatic build_stimulus();
    red_types_pkg::route_mask_t exp_m;
    red_types_pkg::route_mask_t out_m;
    red_types_pkg::red_hdr_t    hdr [`RED_NUM_ROUTES];
    red_types_pkg::red_data_t   dat [`RED_NUM_ROUTES];
    red_types_pkg::red_data_t   acc;
    logic [1:0]                 op;
    logic [31:0]                tmp;
    for (int k = 0; k < num_tests; k++) begin
      op = 2'd0;
      if (k < warmup_tests) begin
        // Back-to-back two-route adds keep several requests in flight
        exp_m = 4'b0001 | (4'b0001 << (1 + rand_bits(2) % 3));
      end else begin
        if (k == warmup_tests) begin
          exp_m = 4'b1111;
        end else if (k == warmup_tests + 1) begin
          exp_m = 4'b0111;
        end else begin
          tmp   = rand_bits(3);
          exp_m = {tmp[2:0], 1'b1};
        end
        if (exp_m == 4'b0001) begin
          exp_m = 4'b0011;
        end
        op = 2'(rand_bits(2));
        if (op == 2'd3) begin
          op = 2'd2;
        end
      end
      out_m = 4'(rand_bits(4));
      // Each result fans out to at least two routes
      if ($countones(out_m) < 2) begin
        out_m = out_m | 4'b1001;
      end
      for (int r = 0; r < `RED_NUM_ROUTES; r++) begin
        if (exp_m[r]) begin
          tmp    = rand_bits(6);
          hdr[r] = {tmp[5:0], op};
          dat[r] = rand_bits(32);
          stim_q[r].push_back({hdr[r], dat[r], exp_m, out_m});
        end
      end
      // Chain in ascending route order starting from the lowest route
      acc = dat[0];
      for (int r = 1; r < `RED_NUM_ROUTES; r++) begin
        if (exp_m[r]) begin
          acc = reduce_pair(op, acc, dat[r]);
        end
      end
      for (int r = 0; r < `RED_NUM_ROUTES; r++) begin
        if (out_m[r]) begin
          expect_q[r].push_back({hdr[0], acc});
          total_out++;
        end
      end
    end
  endtask

  // Inputs change 1 ns after the rising edge
  always @(posedge clk_i) begin
    #1;
    for (int r = 0; r < `RED_NUM_ROUTES; r++) begin
      valid_i[r] = started && (stim_q[r].size() != 0);
      if (valid_i[r]) begin
        {hdr_i[r], data_i[r], exp_mask_i[r], out_mask_i[r]} = stim_q[r][0];
      end
      ready_i[r] = (rand_bits(2) != 0);
    end
    req_ready_i  = (rand_bits(2) != 0);
    resp_valid_i = (model_q.size() != 0) && (due_q[0] <= cycle);
    resp_data_i  = resp_valid_i ? model_q[0] : '0;
  end

  // Handshakes are sampled at the falling edge where all values have settled
  always @(negedge clk_i) begin
    logic [39:0] want;
    if (rst_n_i) begin
      cycle++;
      for (int r = 0; r < `RED_NUM_ROUTES; r++) begin
        if (valid_i[r] && ready_o[r]) begin
          void'(stim_q[r].pop_front());
        end
      end
      if (resp_valid_i && resp_ready_o) begin
        void'(model_q.pop_front());
        void'(due_q.pop_front());
      end
      if (req_valid_o && req_ready_i) begin
        if (model_q.size() != 0) begin
          overlap_seen = 1'b1;
        end
        model_q.push_back(reduce_pair(req_op_o, req_op1_o, req_op2_o));
        due_q.push_back(cycle + model_latency);
      end
      for (int r = 0; r < `RED_NUM_ROUTES; r++) begin
        if (valid_o[r]) begin
          assert (expect_q[r].size() != 0)
            else stop_with_failure($sformatf("route %0d raised valid_o with no result due", r));
          want = expect_q[r][0];
          if (ready_i[r]) begin
            assert ({hdr_o[r], data_o[r]} == want)
              else stop_with_failure($sformatf(
                "mismatch hdr_o/data_o[%0d] got 0x%0h/0x%0h expected 0x%0h/0x%0h",
                r, hdr_o[r], data_o[r], want[39:32], want[31:0]));
            void'(expect_q[r].pop_front());
            recv_cnt++;
          end
        end
      end
    end
  end

  // The bound checker counts its failed assertions
  initial begin
    wait (DUT.u_chk.fail_cnt != 0);
    stop_with_failure("a protocol assertion of the bound checker failed");
  end

  initial begin
    #(timeout_ns * 1ns);
    stop_with_failure("timeout while waiting for the reduction results");
  end

  initial begin
    string end_fault;
    lfsr_q       = lfsr_seed;
    rst_n_i      = 1'b0;
    started      = 1'b0;
    overlap_seen = 1'b0;
    cycle        = 0;
    total_out    = 0;
    recv_cnt     = 0;
    valid_i      = '0;
    ready_i      = '0;
    req_ready_i  = 1'b0;
    resp_valid_i = 1'b0;
    resp_data_i  = '0;
    for (int r = 0; r < `RED_NUM_ROUTES; r++) begin
      hdr_i[r]      = '0;
      data_i[r]     = '0;
      exp_mask_i[r] = '0;
      out_mask_i[r] = '0;
    end
    build_stimulus();
    repeat (10) @(posedge clk_i);
    #1 rst_n_i = 1'b1;
    // A few idle cycles let the checker see the outputs stay low after reset
    repeat (3) @(posedge clk_i);
    started = 1'b1;
    while (recv_cnt != total_out) begin
      @(negedge clk_i);
    end
    repeat (5) @(negedge clk_i);
    end_fault = "";
    // Every request sent to the reduction unit must have had its result taken
    if (model_q.size() != 0) begin
      end_fault = "the reduction unit still holds results the DUT never took";
    end
    if (!overlap_seen) begin
      end_fault = "no request was issued while another one was outstanding";
    end
    if (end_fault == "") begin
      $display("TEST OK");
      $finish;
    end else begin
      stop_with_failure(end_fault);
    end
  end

endmodule
